//--- logic/matmul_consts.svh
`ifndef MATMUL_CONSTS_SVH
`define MATMUL_CONSTS_SVH

// Element and address widths
`define MM_DWIDTH 8
`define MM_AWIDTH 13
`define MM_MEM_SIZE 8192

// Matrix order and memory word step
`define MM_SIZE 4
`define MM_ADDR_STEP 4

// Idle address, the last word of memory
`define MM_ADDR_PARK (`MM_MEM_SIZE - `MM_ADDR_STEP)

// Register stages from cell input to accumulator
`define MM_MAC_STAGES 3

// Count values that mark the end of a run
`define MM_ROW_LATCH_CYCLE 16
`define MM_DONE_CYCLE 19

`endif

//--- logic/matmul_pkg.sv
`default_nettype none

`include "matmul_consts.svh"

package matmul_pkg;

  // One matrix element
  typedef logic [`MM_DWIDTH-1:0] elem_t;

  // One memory word, lane 0 in the low byte
  typedef elem_t [`MM_SIZE-1:0] row_t;

  // Full multiplier product before saturation
  typedef logic [2*`MM_DWIDTH-1:0] prod_t;

  typedef logic [`MM_AWIDTH-1:0] addr_t;

  // Run cycle counter
  typedef logic [6:0] count_t;

endpackage

`default_nettype wire

//--- logic/mac_cell.sv
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module mac_cell (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 i_clear,
  input  wire matmul_pkg::elem_t i_a,
  input  wire matmul_pkg::elem_t i_b,
  output matmul_pkg::elem_t   o_a,
  output matmul_pkg::elem_t   o_b,
  output matmul_pkg::elem_t   o_acc
);

  logic              cell_clear;
  matmul_pkg::prod_t prod_q;
  matmul_pkg::elem_t sat_val;

  assign cell_clear = reset || i_clear;

  // Operand registers double as the pass-through to the neighbours
  always_ff @(posedge clk) begin
    if (cell_clear) begin
      o_a    <= '0;
      o_b    <= '0;
      prod_q <= '0;
    end else begin
      o_a    <= i_a;
      o_b    <= i_b;
      prod_q <= matmul_pkg::prod_t'(o_a) * matmul_pkg::prod_t'(o_b);
    end
  end

  ////////////////////////////////////////////////////////////
  // Saturate the product down to one element
  ////////////////////////////////////////////////////////////

  // Top product bit acts as the sign, bits 14 to 7 flag overflow
  always_comb begin
    if (!prod_q[2*`MM_DWIDTH-1]) begin
      if (|prod_q[2*`MM_DWIDTH-2:`MM_DWIDTH-1]) begin
        sat_val = {1'b0, {(`MM_DWIDTH-1){1'b1}}};
      end else begin
        sat_val = {1'b0, prod_q[`MM_DWIDTH-2:0]};
      end
    end else begin
      if (|prod_q[2*`MM_DWIDTH-2:`MM_DWIDTH-1]) begin
        sat_val = {1'b1, prod_q[`MM_DWIDTH-2:0]};
      end else begin
        sat_val = {1'b1, {(`MM_DWIDTH-1){1'b0}}};
      end
    end
  end

  // Accumulator wraps modulo 256
  always_ff @(posedge clk) begin
    if (cell_clear) begin
      o_acc <= '0;
    end else begin
      o_acc <= o_acc + sat_val;
    end
  end

  // Nothing reaches the accumulator until the pipeline has refilled
  a_acc_refill: assert property (
    @(posedge clk) disable iff (reset)
    i_clear |=> (o_acc == '0) [*`MM_MAC_STAGES]
  );

endmodule

`default_nettype wire

//--- logic/matmul_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module matmul_sequencer (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 i_start,
  output matmul_pkg::count_t  o_count,
  output matmul_pkg::addr_t   o_a_addr,
  output matmul_pkg::addr_t   o_b_addr,
  output logic                o_done
);

  logic              run_clear;
  matmul_pkg::addr_t rd_addr;

  // A low start level aborts the run and rewinds everything
  assign run_clear = reset || !i_start;

  ////////////////////////////////////////////////////////////
  // Cycle counter and done flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (run_clear) begin
      o_count <= '0;
      o_done  <= 1'b0;
    end else if (o_count == matmul_pkg::count_t'(`MM_DONE_CYCLE)) begin
      // Count holds here until start drops
      o_done <= 1'b1;
    end else begin
      o_count <= o_count + matmul_pkg::count_t'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand read pointer
  ////////////////////////////////////////////////////////////

  // Column k of A and row k of B share word address k*4
  always_ff @(posedge clk) begin
    if (run_clear || (o_count >= matmul_pkg::count_t'(`MM_SIZE))) begin
      rd_addr <= matmul_pkg::addr_t'(`MM_ADDR_PARK);
    end else begin
      rd_addr <= matmul_pkg::addr_t'(o_count * `MM_ADDR_STEP);
    end
  end

  assign o_a_addr = rd_addr;
  assign o_b_addr = rd_addr;

  // Done must not let the counter run on
  a_count_frozen: assert property (
    @(posedge clk) disable iff (reset)
    (o_done && i_start) |=> $stable(o_count)
  );

endmodule

`default_nettype wire

//--- logic/systolic_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module systolic_array (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 i_start,
  input  wire matmul_pkg::row_t  i_a_data,
  input  wire matmul_pkg::row_t  i_b_data,
  output wire matmul_pkg::row_t [`MM_SIZE-1:0] o_c_grid
);

  logic skew_clear;

  // Horizontal A links, column MM_SIZE is the unused right edge
  wire matmul_pkg::elem_t a_link [`MM_SIZE][`MM_SIZE+1];
  // Vertical B links, row MM_SIZE is the unused bottom edge
  wire matmul_pkg::elem_t b_link [`MM_SIZE+1][`MM_SIZE];

  assign skew_clear = reset || !i_start;

  ////////////////////////////////////////////////////////////
  // Input skew, lane i waits i cycles
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `MM_SIZE; i++) begin : g_skew
    if (i == 0) begin : g_direct
      assign a_link[0][0] = i_a_data[0];
      assign b_link[0][0] = i_b_data[0];
    end else begin : g_delay
      matmul_pkg::elem_t a_pipe [i];
      matmul_pkg::elem_t b_pipe [i];

      always_ff @(posedge clk) begin
        if (skew_clear) begin
          for (int d = 0; d < i; d++) begin
            a_pipe[d] <= '0;
            b_pipe[d] <= '0;
          end
        end else begin
          a_pipe[0] <= i_a_data[i];
          b_pipe[0] <= i_b_data[i];
          for (int d = 1; d < i; d++) begin
            a_pipe[d] <= a_pipe[d-1];
            b_pipe[d] <= b_pipe[d-1];
          end
        end
      end

      // A lane i feeds row i, B lane i feeds column i
      assign a_link[i][0] = a_pipe[i-1];
      assign b_link[0][i] = b_pipe[i-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // Cell grid, A moves right and B moves down
  ////////////////////////////////////////////////////////////

  for (genvar r = 0; r < `MM_SIZE; r++) begin : g_row
    for (genvar c = 0; c < `MM_SIZE; c++) begin : g_col
      mac_cell u_cell (
        .clk     (clk),
        .reset   (reset),
        .i_clear (!i_start),
        .i_a     (a_link[r][c]),
        .i_b     (b_link[r][c]),
        .o_a     (a_link[r][c+1]),
        .o_b     (b_link[r+1][c]),
        .o_acc   (o_c_grid[r][c])
      );
    end
  end

endmodule

`default_nettype wire

//--- logic/row_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module row_collector (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 i_start,
  input  wire                 i_done,
  input  wire matmul_pkg::count_t i_count,
  input  wire matmul_pkg::row_t [`MM_SIZE-1:0] i_c_grid,
  output matmul_pkg::row_t    o_c_data,
  output matmul_pkg::addr_t   o_c_addr,
  output logic                o_c_valid
);

  localparam int ROW_W = $clog2(`MM_SIZE);

  logic             latch_start;
  logic             capturing;
  logic [ROW_W-1:0] row_idx;

  // Row 0 leaves on the edge that moves the count onto the latch cycle
  assign latch_start = (i_count == matmul_pkg::count_t'(`MM_ROW_LATCH_CYCLE - 1));

  always_ff @(posedge clk) begin
    if (reset || !i_start || i_done) begin
      capturing <= 1'b0;
      row_idx   <= '0;
      o_c_valid <= 1'b0;
      o_c_data  <= '0;
      o_c_addr  <= matmul_pkg::addr_t'(`MM_ADDR_PARK);
    end else if (latch_start || capturing) begin
      // One row per cycle, the address follows the row number
      o_c_valid <= 1'b1;
      o_c_data  <= i_c_grid[row_idx];
      o_c_addr  <= matmul_pkg::addr_t'(row_idx * `MM_ADDR_STEP);
      row_idx   <= row_idx + ROW_W'(1);
      capturing <= (row_idx != ROW_W'(`MM_SIZE - 1));
    end else begin
      o_c_valid <= 1'b0;
      o_c_data  <= '0;
      o_c_addr  <= matmul_pkg::addr_t'(`MM_ADDR_PARK);
    end
  end

  // Last row must be out before the sequencer raises done
  a_valid_before_done: assert property (
    @(posedge clk) disable iff (reset)
    !(o_c_valid && i_done)
  );

endmodule

`default_nettype wire

//--- logic/matmul_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module matmul_top (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 i_start,
  output wire                 o_done,
  input  wire matmul_pkg::row_t  i_a_data,
  input  wire matmul_pkg::row_t  i_b_data,
  output wire matmul_pkg::addr_t o_a_addr,
  output wire matmul_pkg::addr_t o_b_addr,
  output wire matmul_pkg::addr_t o_c_addr,
  output wire matmul_pkg::row_t  o_c_data,
  output wire                 o_c_valid
);

  wire matmul_pkg::count_t               count;
  wire matmul_pkg::row_t [`MM_SIZE-1:0]  c_grid;

  // Address generation and run timing
  matmul_sequencer u_sequencer (
    .clk      (clk),
    .reset    (reset),
    .i_start  (i_start),
    .o_count  (count),
    .o_a_addr (o_a_addr),
    .o_b_addr (o_b_addr),
    .o_done   (o_done)
  );

  systolic_array u_array (
    .clk      (clk),
    .reset    (reset),
    .i_start  (i_start),
    .i_a_data (i_a_data),
    .i_b_data (i_b_data),
    .o_c_grid (c_grid)
  );

  // Result rows out to memory
  row_collector u_collector (
    .clk       (clk),
    .reset     (reset),
    .i_start   (i_start),
    .i_done    (o_done),
    .i_count   (count),
    .i_c_grid  (c_grid),
    .o_c_data  (o_c_data),
    .o_c_addr  (o_c_addr),
    .o_c_valid (o_c_valid)
  );

endmodule

`default_nettype wire

//--- test/matmul_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "matmul_consts.svh"

module matmul_tb;

  localparam int NUM_ENTRIES  = 8;
  localparam int RUN_COUNT    = NUM_ENTRIES + 2;
  localparam int RESET_CYCLES = 16;
  localparam int CYCLE_LIMIT  = 30 * RUN_COUNT + 50 + RESET_CYCLES;
  localparam int HOLD_CYCLES  = 3;
  localparam int ABORT_CYCLES = 9;
  localparam int RUN_CYCLES   = `MM_DONE_CYCLE + 1;
  localparam matmul_pkg::addr_t PARK_ADDR = matmul_pkg::addr_t'(`MM_ADDR_PARK);

  logic                 clk = 1'b0;
  logic                 reset = 1'b1;
  logic                 i_start = 1'b0;
  matmul_pkg::row_t     i_a_data = '0;
  matmul_pkg::row_t     i_b_data = '0;
  wire                  o_done;
  wire                  o_c_valid;
  wire matmul_pkg::addr_t o_a_addr;
  wire matmul_pkg::addr_t o_b_addr;
  wire matmul_pkg::addr_t o_c_addr;
  wire matmul_pkg::row_t  o_c_data;

  integer seed = 32'hd28eac47;
  int     cycle_count = 0;

  // One stimulus and expected result entry per run
  matmul_pkg::elem_t tbl_a [NUM_ENTRIES][`MM_SIZE][`MM_SIZE];
  matmul_pkg::elem_t tbl_b [NUM_ENTRIES][`MM_SIZE][`MM_SIZE];
  matmul_pkg::row_t  tbl_c [NUM_ENTRIES][`MM_SIZE];

  // Operand memory holds one word per column of A and row of B
  matmul_pkg::row_t  mem_a [`MM_SIZE];
  matmul_pkg::row_t  mem_b [`MM_SIZE];
  matmul_pkg::addr_t a_addr_prev = '0;
  matmul_pkg::addr_t b_addr_prev = '0;

  matmul_top dut (
    .clk       (clk),
    .reset     (reset),
    .i_start   (i_start),
    .o_done    (o_done),
    .i_a_data  (i_a_data),
    .i_b_data  (i_b_data),
    .o_a_addr  (o_a_addr),
    .o_b_addr  (o_b_addr),
    .o_c_addr  (o_c_addr),
    .o_c_data  (o_c_data),
    .o_c_valid (o_c_valid)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Memory model with one cycle of read latency
  ////////////////////////////////////////////////////////////

  function automatic matmul_pkg::row_t fetch_word(input logic sel_b,
                                                  input matmul_pkg::addr_t addr);
    if (addr[1:0] != 2'b00 || addr >= matmul_pkg::addr_t'(4 * `MM_SIZE)) begin
      return '0;
    end
    return sel_b ? mem_b[addr[3:2]] : mem_a[addr[3:2]];
  endfunction

  // Address seen at the previous falling edge was latched at the last rising edge
  always @(negedge clk) begin
    i_a_data    <= fetch_word(1'b0, a_addr_prev);
    i_b_data    <= fetch_word(1'b1, b_addr_prev);
    a_addr_prev <= o_a_addr;
    b_addr_prev <= o_b_addr;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic compare_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERR time=%0t %s expected=0x%0h actual=0x%0h", $time, sig, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("%s at time %0t", what, $time);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_idle();
    compare_value("o_done", 32'd0, 32'(o_done));
    compare_value("o_c_valid", 32'd0, 32'(o_c_valid));
    compare_value("o_c_data", 32'd0, 32'(o_c_data));
    compare_value("o_a_addr", 32'(PARK_ADDR), 32'(o_a_addr));
    compare_value("o_b_addr", 32'(PARK_ADDR), 32'(o_b_addr));
    compare_value("o_c_addr", 32'(PARK_ADDR), 32'(o_c_addr));
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model and table setup
  ////////////////////////////////////////////////////////////

  // Top product bit is the sign and bits 14 to 7 flag overflow
  function automatic matmul_pkg::elem_t saturate(input logic [15:0] prod);
    logic overflow;
    overflow = |prod[14:7];
    if (!prod[15]) begin
      return overflow ? 8'h7f : {1'b0, prod[6:0]};
    end
    return overflow ? {1'b1, prod[6:0]} : 8'h80;
  endfunction

  function automatic matmul_pkg::elem_t random_elem();
    logic [31:0] word;
    word = $random(seed);
    return word[7:0];
  endfunction

  task automatic build_table();
    matmul_pkg::elem_t acc;
    logic [15:0]       prod;
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      for (int i = 0; i < `MM_SIZE; i++) begin
        for (int j = 0; j < `MM_SIZE; j++) begin
          case (e)
            0: tbl_a[e][i][j] = (i == j) ? 8'd1 : 8'd0;
            1: tbl_a[e][i][j] = 8'd1;
            2: tbl_a[e][i][j] = random_elem() | 8'h80;
            3: tbl_a[e][i][j] = 8'd0;
            default: tbl_a[e][i][j] = random_elem();
          endcase
          tbl_b[e][i][j] = (e == 1) ? 8'd1 : random_elem();
          if (e == 2) begin
            tbl_b[e][i][j] = tbl_b[e][i][j] | 8'h80;
          end
        end
      end
      // Expected C with saturated products and wrapped sums
      for (int i = 0; i < `MM_SIZE; i++) begin
        for (int j = 0; j < `MM_SIZE; j++) begin
          acc = '0;
          for (int k = 0; k < `MM_SIZE; k++) begin
            prod = 16'(tbl_a[e][i][k]) * 16'(tbl_b[e][k][j]);
            acc  = acc + saturate(prod);
          end
          tbl_c[e][i][j] = acc;
        end
      end
    end
  endtask

  // Word k of A is column k and word k of B is row k
  task automatic load_memory(input int idx);
    for (int k = 0; k < `MM_SIZE; k++) begin
      for (int n = 0; n < `MM_SIZE; n++) begin
        mem_a[k][n] = tbl_a[idx][n][k];
        mem_b[k][n] = tbl_b[idx][k][n];
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Runs
  ////////////////////////////////////////////////////////////

  task automatic run_entry(input int idx);
    int   addr_idx;
    int   row_cnt;
    int   cycles;
    logic finished;
    load_memory(idx);
    addr_idx = 0;
    row_cnt  = 0;
    cycles   = 0;
    finished = 1'b0;
    i_start  = 1'b1;
    while (!finished) begin
      @(negedge clk);
      cycles++;
      if (o_a_addr != PARK_ADDR) begin
        check_true(addr_idx < `MM_SIZE, "Read address left park more than four times");
        compare_value("o_a_addr", 32'(addr_idx * `MM_ADDR_STEP), 32'(o_a_addr));
        compare_value("o_b_addr", 32'(addr_idx * `MM_ADDR_STEP), 32'(o_b_addr));
        addr_idx++;
      end else begin
        compare_value("o_b_addr", 32'(PARK_ADDR), 32'(o_b_addr));
      end
      if (o_c_valid) begin
        check_true(row_cnt < `MM_SIZE, "More than four result rows were written");
        compare_value("o_c_addr", 32'(row_cnt * `MM_ADDR_STEP), 32'(o_c_addr));
        compare_value("o_c_data", 32'(tbl_c[idx][row_cnt]), 32'(o_c_data));
        row_cnt++;
      end
      if (o_done) begin
        check_true(row_cnt == `MM_SIZE, "o_done rose before all four rows were written");
        check_true(addr_idx == `MM_SIZE, "o_done rose before all four words were read");
        compare_value("o_c_valid", 32'd0, 32'(o_c_valid));
        compare_value("cycles to o_done", 32'(RUN_CYCLES), 32'(cycles));
        finished = 1'b1;
      end
    end
    // Done holds while start is held
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      compare_value("o_done", 32'd1, 32'(o_done));
      compare_value("o_c_valid", 32'd0, 32'(o_c_valid));
    end
    i_start = 1'b0;
    @(negedge clk);
    check_idle();
    @(negedge clk);
  endtask

  // Start drops in the middle of the operand stream
  task automatic abort_run(input int idx);
    load_memory(idx);
    i_start = 1'b1;
    repeat (ABORT_CYCLES) @(negedge clk);
    i_start = 1'b0;
    @(negedge clk);
    check_idle();
    @(negedge clk);
  endtask

  initial begin
    build_table();
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_idle();
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      run_entry(e);
    end
    abort_run(NUM_ENTRIES - 1);
    run_entry(2);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+logic
logic/matmul_pkg.sv
logic/mac_cell.sv
logic/matmul_sequencer.sv
logic/systolic_array.sv
logic/row_collector.sv
logic/matmul_top.sv
test/matmul_tb.sv

//--- Makefile
# Verilator flow for the systolic matrix multiplier

VERILATOR  ?= verilator
TOP        ?= matmul_tb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Test failed
PASS_MSG   ?= Test passed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported a failure"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a verdict"; exit 1; \
	else \
	  echo "Simulation clean"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
